/* hw/iter_pkg.sv */
`default_nettype none

package iter_pkg;

    typedef logic [2:0]  ns_id_t;
    typedef logic [4:0]  ns_index_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] count_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [3:0]  fn_t;

    // entries per namespace bank
    localparam int TABLE_DEPTH = 2 ** $bits(ns_index_t);

    localparam opcode_t OP_LOOP = 4'd7;

    // loop functions
    localparam fn_t FN_SET_STRIDE = 4'd0;
    localparam fn_t FN_SET_ITER   = 4'd1;
    localparam fn_t FN_START      = 4'd2;
    localparam fn_t FN_SET_BASE   = 4'd3;

endpackage

`default_nettype wire

/* hw/iter_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module iter_decode #(
    parameter int LOOP_ID_BITS = 2
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     instr_valid,
    input  iter_pkg::opcode_t       instr_opcode,
    input  iter_pkg::fn_t           instr_fn,
    input  wire [LOOP_ID_BITS-1:0]  instr_loop_id,
    input  iter_pkg::count_t        instr_immediate,
    input  wire                     busy,
    output logic                    instr_ready,
    output logic                    rd_en,
    output logic                    cmd_set_iter,
    output logic                    cmd_set_stride,
    output logic                    cmd_set_base,
    output logic                    cmd_start,
    output logic [LOOP_ID_BITS-1:0] cmd_loop_id,
    output iter_pkg::count_t        cmd_count
);
    import iter_pkg::*;

    logic accept;
    logic is_loop;

    assign instr_ready = !busy;
    assign accept      = instr_valid && instr_ready;
    assign is_loop     = (instr_opcode == OP_LOOP);

    // table data arrives one cycle after the read
    assign rd_en = accept && is_loop;

    // commands delayed one cycle to meet the table data
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_set_iter   <= 1'b0;
            cmd_set_stride <= 1'b0;
            cmd_set_base   <= 1'b0;
            cmd_start      <= 1'b0;
        end else begin
            cmd_set_iter   <= rd_en && (instr_fn == FN_SET_ITER);
            cmd_set_stride <= rd_en && (instr_fn == FN_SET_STRIDE);
            cmd_set_base   <= rd_en && (instr_fn == FN_SET_BASE);
            cmd_start      <= rd_en && (instr_fn == FN_START);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_loop_id <= instr_loop_id;
            cmd_count   <= instr_immediate;
        end
    end

endmodule

`default_nettype wire

/* hw/base_stride_table.sv */
`timescale 1ns/1ps
`default_nettype none

module base_stride_table #(
    parameter int NUM_NS = 6
) (
    input  wire                 clk,
    input  wire                 wr_en,
    input  iter_pkg::ns_id_t    wr_ns,
    input  iter_pkg::ns_index_t wr_index,
    input  iter_pkg::addr_t     wr_data,
    input  wire                 rd_en,
    input  iter_pkg::ns_id_t    rd_ns_src1,
    input  iter_pkg::ns_index_t rd_index_src1,
    input  iter_pkg::ns_id_t    rd_ns_src2,
    input  iter_pkg::ns_index_t rd_index_src2,
    input  iter_pkg::ns_id_t    rd_ns_dest,
    input  iter_pkg::ns_index_t rd_index_dest,
    output iter_pkg::addr_t     rd_src1,
    output iter_pkg::addr_t     rd_src2,
    output iter_pkg::addr_t     rd_dest
);
    import iter_pkg::*;

    addr_t     mem [NUM_NS][TABLE_DEPTH];
    ns_id_t    rd_ns [3];
    ns_index_t rd_index [3];
    addr_t     rd_data [3];

    assign rd_ns[0]    = rd_ns_src1;
    assign rd_ns[1]    = rd_ns_src2;
    assign rd_ns[2]    = rd_ns_dest;
    assign rd_index[0] = rd_index_src1;
    assign rd_index[1] = rd_index_src2;
    assign rd_index[2] = rd_index_dest;

    // out of range namespaces are dropped
    always_ff @(posedge clk) begin
        if (wr_en && (wr_ns < NUM_NS)) begin
            mem[wr_ns][wr_index] <= wr_data;
        end
    end

    // three registered read ports, output holds on a bad namespace
    always_ff @(posedge clk) begin
        for (int p = 0; p < 3; p++) begin
            if (rd_en && (rd_ns[p] < NUM_NS)) begin
                rd_data[p] <= mem[rd_ns[p]][rd_index[p]];
            end
        end
    end

    assign rd_src1 = rd_data[0];
    assign rd_src2 = rd_data[1];
    assign rd_dest = rd_data[2];

endmodule

`default_nettype wire

/* hw/loop_config.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_config #(
    parameter int NUM_LOOPS    = 4,
    parameter int LOOP_ID_BITS = 2
) (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire                                       cmd_set_iter,
    input  wire                                       cmd_set_stride,
    input  wire                                       cmd_set_base,
    input  wire [LOOP_ID_BITS-1:0]                    cmd_loop_id,
    input  iter_pkg::count_t                          cmd_count,
    input  iter_pkg::addr_t                           base_src1,
    input  iter_pkg::addr_t                           base_src2,
    input  iter_pkg::addr_t                           base_dest,
    input  iter_pkg::addr_t                           stride_src1,
    input  iter_pkg::addr_t                           stride_src2,
    input  iter_pkg::addr_t                           stride_dest,
    input  wire                                       loop_done,
    output iter_pkg::count_t [NUM_LOOPS-1:0]          counts,
    output iter_pkg::addr_t  [NUM_LOOPS-1:0]          strides_src1,
    output iter_pkg::addr_t  [NUM_LOOPS-1:0]          strides_src2,
    output iter_pkg::addr_t  [NUM_LOOPS-1:0]          strides_dest,
    output iter_pkg::addr_t                           base_out_src1,
    output iter_pkg::addr_t                           base_out_src2,
    output iter_pkg::addr_t                           base_out_dest
);

    always_ff @(posedge clk) begin
        if (reset || loop_done) begin
            counts        <= '0;
            strides_src1  <= '0;
            strides_src2  <= '0;
            strides_dest  <= '0;
            base_out_src1 <= '0;
            base_out_src2 <= '0;
            base_out_dest <= '0;
        end else begin
            if (cmd_set_iter) begin
                counts[cmd_loop_id] <= cmd_count;
            end
            if (cmd_set_stride) begin
                strides_src1[cmd_loop_id] <= stride_src1;
                strides_src2[cmd_loop_id] <= stride_src2;
                strides_dest[cmd_loop_id] <= stride_dest;
            end
            if (cmd_set_base) begin
                base_out_src1 <= base_src1;
                base_out_src2 <= base_src2;
                base_out_dest <= base_dest;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/nested_loop_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module nested_loop_gen #(
    parameter int NUM_LOOPS = 4
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              cmd_start,
    input  iter_pkg::count_t [NUM_LOOPS-1:0] counts,
    input  iter_pkg::addr_t  [NUM_LOOPS-1:0] strides_src1,
    input  iter_pkg::addr_t  [NUM_LOOPS-1:0] strides_src2,
    input  iter_pkg::addr_t  [NUM_LOOPS-1:0] strides_dest,
    input  iter_pkg::addr_t                  base_src1,
    input  iter_pkg::addr_t                  base_src2,
    input  iter_pkg::addr_t                  base_dest,
    input  wire                              gen_ready,
    output logic                             gen_valid,
    output iter_pkg::addr_t                  gen_src1,
    output iter_pkg::addr_t                  gen_src2,
    output iter_pkg::addr_t                  gen_dest,
    output logic                             gen_last,
    output logic                             busy,
    output logic                             loop_done
);
    import iter_pkg::*;

    count_t                 idx [NUM_LOOPS];
    addr_t                  offs [3][NUM_LOOPS];
    addr_t [NUM_LOOPS-1:0]  strides [3];
    addr_t                  bases [3];
    addr_t                  addr [3];
    logic [NUM_LOOPS-1:0]   at_max;
    logic [NUM_LOOPS-1:0]   carry;
    logic                   running;
    logic                   fire;

    assign strides[0] = strides_src1;
    assign strides[1] = strides_src2;
    assign strides[2] = strides_dest;
    assign bases[0]   = base_src1;
    assign bases[1]   = base_src2;
    assign bases[2]   = base_dest;

    ////////////////////////////////////////
    // odometer
    ////////////////////////////////////////

    // a zero count runs once, same as one
    always_comb begin
        for (int l = 0; l < NUM_LOOPS; l++) begin
            at_max[l] = (counts[l] == '0) || (idx[l] == counts[l] - 1'b1);
        end
        carry[NUM_LOOPS-1] = 1'b1;
        for (int l = NUM_LOOPS - 2; l >= 0; l--) begin
            carry[l] = carry[l+1] && at_max[l+1];
        end
    end

    assign fire      = running && gen_ready;
    assign gen_valid = running;
    assign gen_last  = &at_max;
    assign loop_done = fire && gen_last;
    // start pulse counts as busy so nothing slips in behind it
    assign busy      = running || cmd_start;

    always_ff @(posedge clk) begin
        if (reset || cmd_start) begin
            running <= cmd_start && !reset;
            for (int l = 0; l < NUM_LOOPS; l++) begin
                idx[l] <= '0;
                for (int o = 0; o < 3; o++) begin
                    offs[o][l] <= '0;
                end
            end
        end else if (fire) begin
            if (gen_last) begin
                running <= 1'b0;
            end
            for (int l = 0; l < NUM_LOOPS; l++) begin
                if (carry[l]) begin
                    idx[l] <= at_max[l] ? '0 : idx[l] + 1'b1;
                    for (int o = 0; o < 3; o++) begin
                        offs[o][l] <= at_max[l] ? '0 : offs[o][l] + strides[o][l];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // address sums
    ////////////////////////////////////////

    // wraps to 16 bits
    always_comb begin
        for (int o = 0; o < 3; o++) begin
            addr[o] = bases[o];
            for (int l = 0; l < NUM_LOOPS; l++) begin
                addr[o] = addr[o] + offs[o][l];
            end
        end
    end

    assign gen_src1 = addr[0];
    assign gen_src2 = addr[1];
    assign gen_dest = addr[2];

endmodule

`default_nettype wire

/* hw/addr_result.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_result (
    input  wire             clk,
    input  wire             reset,
    input  wire             gen_valid,
    input  iter_pkg::addr_t gen_src1,
    input  iter_pkg::addr_t gen_src2,
    input  iter_pkg::addr_t gen_dest,
    input  wire             gen_last,
    input  wire             addr_ready,
    output logic            gen_ready,
    output logic            addr_valid,
    output iter_pkg::addr_t addr_src1,
    output iter_pkg::addr_t addr_src2,
    output iter_pkg::addr_t addr_dest,
    output logic            addr_last
);
    import iter_pkg::*;

    localparam int ENTRY_W = 3 * $bits(addr_t) + 1;

    logic [ENTRY_W-1:0] entry [2];
    logic               wr_ptr;
    logic               rd_ptr;
    logic [1:0]         fill;
    logic               push;
    logic               pop;

    // room for one more while one entry waits
    assign gen_ready  = (fill != 2'd2);
    assign addr_valid = (fill != 2'd0);
    assign push       = gen_valid && gen_ready;
    assign pop        = addr_valid && addr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            fill   <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            fill <= fill + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= {gen_last, gen_dest, gen_src2, gen_src1};
        end
    end

    assign {addr_last, addr_dest, addr_src2, addr_src1} = entry[rd_ptr];

endmodule

`default_nettype wire

/* hw/iterator_top.sv */
`timescale 1ns/1ps
`default_nettype none

module iterator_top #(
    parameter int NUM_NS       = 6,
    parameter int NUM_LOOPS    = 4,
    parameter int LOOP_ID_BITS = 2
) (
    input  wire                    clk,
    input  wire                    reset,
    // instructions
    input  wire                    instr_valid,
    output logic                   instr_ready,
    input  iter_pkg::opcode_t      instr_opcode,
    input  iter_pkg::fn_t          instr_fn,
    input  wire [LOOP_ID_BITS-1:0] instr_loop_id,
    input  iter_pkg::count_t       instr_immediate,
    input  iter_pkg::ns_id_t       src1_ns,
    input  iter_pkg::ns_index_t    src1_index,
    input  iter_pkg::ns_id_t       src2_ns,
    input  iter_pkg::ns_index_t    src2_index,
    input  iter_pkg::ns_id_t       dest_ns,
    input  iter_pkg::ns_index_t    dest_index,
    // table writes
    input  wire                    tbl_wr_valid,
    input  wire                    tbl_wr_stride,
    input  iter_pkg::ns_id_t       tbl_wr_ns,
    input  iter_pkg::ns_index_t    tbl_wr_index,
    input  iter_pkg::addr_t        tbl_wr_data,
    // address triples
    output logic                   addr_valid,
    input  wire                    addr_ready,
    output iter_pkg::addr_t        addr_src1,
    output iter_pkg::addr_t        addr_src2,
    output iter_pkg::addr_t        addr_dest,
    output logic                   addr_last
);
    import iter_pkg::*;

    logic                             busy, rd_en, loop_done;
    logic                             cmd_set_iter, cmd_set_stride, cmd_set_base, cmd_start;
    logic [LOOP_ID_BITS-1:0]          cmd_loop_id;
    count_t                           cmd_count;
    addr_t                            base_src1, base_src2, base_dest;
    addr_t                            stride_src1, stride_src2, stride_dest;
    count_t [NUM_LOOPS-1:0]           counts;
    addr_t  [NUM_LOOPS-1:0]           strides_src1, strides_src2, strides_dest;
    addr_t                            cfg_base_src1, cfg_base_src2, cfg_base_dest;
    logic                             gen_valid, gen_ready, gen_last;
    addr_t                            gen_src1, gen_src2, gen_dest;

    iter_decode #(.LOOP_ID_BITS(LOOP_ID_BITS)) decode_i (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr_opcode(instr_opcode), .instr_fn(instr_fn),
        .instr_loop_id(instr_loop_id), .instr_immediate(instr_immediate), .busy(busy),
        .instr_ready(instr_ready), .rd_en(rd_en),
        .cmd_set_iter(cmd_set_iter), .cmd_set_stride(cmd_set_stride),
        .cmd_set_base(cmd_set_base), .cmd_start(cmd_start),
        .cmd_loop_id(cmd_loop_id), .cmd_count(cmd_count)
    );

    ////////////////////////////////////////
    // tables
    ////////////////////////////////////////

    base_stride_table #(.NUM_NS(NUM_NS)) base_table (
        .clk(clk), .wr_en(tbl_wr_valid && !tbl_wr_stride),
        .wr_ns(tbl_wr_ns), .wr_index(tbl_wr_index), .wr_data(tbl_wr_data),
        .rd_en(rd_en),
        .rd_ns_src1(src1_ns), .rd_index_src1(src1_index),
        .rd_ns_src2(src2_ns), .rd_index_src2(src2_index),
        .rd_ns_dest(dest_ns), .rd_index_dest(dest_index),
        .rd_src1(base_src1), .rd_src2(base_src2), .rd_dest(base_dest)
    );

    base_stride_table #(.NUM_NS(NUM_NS)) stride_table (
        .clk(clk), .wr_en(tbl_wr_valid && tbl_wr_stride),
        .wr_ns(tbl_wr_ns), .wr_index(tbl_wr_index), .wr_data(tbl_wr_data),
        .rd_en(rd_en),
        .rd_ns_src1(src1_ns), .rd_index_src1(src1_index),
        .rd_ns_src2(src2_ns), .rd_index_src2(src2_index),
        .rd_ns_dest(dest_ns), .rd_index_dest(dest_index),
        .rd_src1(stride_src1), .rd_src2(stride_src2), .rd_dest(stride_dest)
    );

    ////////////////////////////////////////
    // execute and result
    ////////////////////////////////////////

    loop_config #(.NUM_LOOPS(NUM_LOOPS), .LOOP_ID_BITS(LOOP_ID_BITS)) config_i (
        .clk(clk), .reset(reset),
        .cmd_set_iter(cmd_set_iter), .cmd_set_stride(cmd_set_stride),
        .cmd_set_base(cmd_set_base), .cmd_loop_id(cmd_loop_id), .cmd_count(cmd_count),
        .base_src1(base_src1), .base_src2(base_src2), .base_dest(base_dest),
        .stride_src1(stride_src1), .stride_src2(stride_src2), .stride_dest(stride_dest),
        .loop_done(loop_done), .counts(counts),
        .strides_src1(strides_src1), .strides_src2(strides_src2),
        .strides_dest(strides_dest),
        .base_out_src1(cfg_base_src1), .base_out_src2(cfg_base_src2),
        .base_out_dest(cfg_base_dest)
    );

    nested_loop_gen #(.NUM_LOOPS(NUM_LOOPS)) gen_i (
        .clk(clk), .reset(reset), .cmd_start(cmd_start), .counts(counts),
        .strides_src1(strides_src1), .strides_src2(strides_src2),
        .strides_dest(strides_dest),
        .base_src1(cfg_base_src1), .base_src2(cfg_base_src2), .base_dest(cfg_base_dest),
        .gen_ready(gen_ready), .gen_valid(gen_valid),
        .gen_src1(gen_src1), .gen_src2(gen_src2), .gen_dest(gen_dest),
        .gen_last(gen_last), .busy(busy), .loop_done(loop_done)
    );

    addr_result result_i (
        .clk(clk), .reset(reset),
        .gen_valid(gen_valid), .gen_src1(gen_src1), .gen_src2(gen_src2),
        .gen_dest(gen_dest), .gen_last(gen_last), .addr_ready(addr_ready),
        .gen_ready(gen_ready), .addr_valid(addr_valid),
        .addr_src1(addr_src1), .addr_src2(addr_src2), .addr_dest(addr_dest),
        .addr_last(addr_last)
    );

endmodule

`default_nettype wire

/* tests/iterator_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module iterator_tb;
    import iter_pkg::*;

    localparam int NUM_NS       = 6;
    localparam int NUM_LOOPS    = 4;
    localparam int LOOP_ID_BITS = 2;
    localparam int TIMEOUT      = 2000;

    logic                    clk;
    logic                    reset;
    logic                    instr_valid;
    logic                    instr_ready;
    opcode_t                 instr_opcode;
    fn_t                     instr_fn;
    logic [LOOP_ID_BITS-1:0] instr_loop_id;
    count_t                  instr_immediate;
    ns_id_t                  src1_ns, src2_ns, dest_ns;
    ns_index_t               src1_index, src2_index, dest_index;
    logic                    tbl_wr_valid;
    logic                    tbl_wr_stride;
    ns_id_t                  tbl_wr_ns;
    ns_index_t               tbl_wr_index;
    addr_t                   tbl_wr_data;
    logic                    addr_valid;
    logic                    addr_ready;
    addr_t                   addr_src1, addr_src2, addr_dest;
    logic                    addr_last;

    // reference model, table [0] is base and [1] is stride
    addr_t       tbl_copy [2][8][32];
    addr_t       last_rd [2][3];
    count_t      cfg_count [NUM_LOOPS];
    addr_t       cfg_stride [3][NUM_LOOPS];
    addr_t       cfg_base [3];
    logic [48:0] exp_q [$];

    // fields of the current pattern record
    int f_op, f_fn, f_lid, f_imm;
    int f_stride, f_ns, f_idx, f_data;
    int rec_ns [3];
    int rec_idx [3];

    int          tests, failed, checks, errors;
    logic        timed_out;
    logic        win_active;
    int          win_total, win_rx, pending_total;
    logic [31:0] lfsr_state;

    iterator_top #(
        .NUM_NS(NUM_NS),
        .NUM_LOOPS(NUM_LOOPS),
        .LOOP_ID_BITS(LOOP_ID_BITS)
    ) iterator_top_i (.*);

    always #4 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(negedge clk) begin
        logic bit_a;
        logic bit_b;
        lfsr_state = lfsr_next(lfsr_state);
        bit_a = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        bit_b = lfsr_state[0];
        // ready about three cycles out of four
        addr_ready = bit_a | bit_b;
    end

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] expected);
        checks++;
        if (got !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    task automatic expand_loop();
        int    total;
        int    rem;
        int    c;
        int    lvl_idx [NUM_LOOPS];
        addr_t a [3];
        total = 1;
        for (int l = 0; l < NUM_LOOPS; l++) begin
            total = total * ((cfg_count[l] == 0) ? 1 : int'(cfg_count[l]));
        end
        for (int n = 0; n < total; n++) begin
            rem = n;
            // innermost level turns fastest
            for (int l = NUM_LOOPS - 1; l >= 0; l--) begin
                c = (cfg_count[l] == 0) ? 1 : int'(cfg_count[l]);
                lvl_idx[l] = rem % c;
                rem = rem / c;
            end
            for (int p = 0; p < 3; p++) begin
                a[p] = cfg_base[p];
                for (int l = 0; l < NUM_LOOPS; l++) begin
                    a[p] = a[p] + lvl_idx[l] * cfg_stride[p][l];
                end
            end
            exp_q.push_back({(n == total - 1), a[2], a[1], a[0]});
        end
        pending_total = total;
        // loop done wipes the whole configuration
        for (int l = 0; l < NUM_LOOPS; l++) begin
            cfg_count[l] = '0;
            for (int p = 0; p < 3; p++) begin
                cfg_stride[p][l] = '0;
            end
        end
        for (int p = 0; p < 3; p++) begin
            cfg_base[p] = '0;
        end
    endtask

    task automatic apply_instr();
        if (f_op == OP_LOOP) begin
            // bad namespaces keep the previous read value
            for (int p = 0; p < 3; p++) begin
                if (rec_ns[p] < NUM_NS) begin
                    last_rd[0][p] = tbl_copy[0][rec_ns[p]][rec_idx[p]];
                    last_rd[1][p] = tbl_copy[1][rec_ns[p]][rec_idx[p]];
                end
            end
            case (f_fn)
                FN_SET_ITER: cfg_count[f_lid] = f_imm;
                FN_SET_STRIDE: begin
                    for (int p = 0; p < 3; p++) begin
                        cfg_stride[p][f_lid] = last_rd[1][p];
                    end
                end
                FN_SET_BASE: begin
                    for (int p = 0; p < 3; p++) begin
                        cfg_base[p] = last_rd[0][p];
                    end
                end
                FN_START: expand_loop();
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////
    // drivers
    ////////////////////////////////////////

    task automatic drive_write();
        if (f_ns < NUM_NS) begin
            tbl_copy[f_stride][f_ns][f_idx] = f_data[15:0];
        end
        tbl_wr_valid  = 1'b1;
        tbl_wr_stride = f_stride[0];
        tbl_wr_ns     = f_ns[2:0];
        tbl_wr_index  = f_idx[4:0];
        tbl_wr_data   = f_data[15:0];
        @(posedge clk);
        @(negedge clk);
        tbl_wr_valid = 1'b0;
    endtask

    task automatic drive_instr();
        int waited;
        apply_instr();
        instr_valid     = 1'b1;
        instr_opcode    = f_op[3:0];
        instr_fn        = f_fn[3:0];
        instr_loop_id   = f_lid[LOOP_ID_BITS-1:0];
        instr_immediate = f_imm[15:0];
        src1_ns         = rec_ns[0][2:0];
        src1_index      = rec_idx[0][4:0];
        src2_ns         = rec_ns[1][2:0];
        src2_index      = rec_idx[1][4:0];
        dest_ns         = rec_ns[2][2:0];
        dest_index      = rec_idx[2][4:0];
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!instr_ready && waited < TIMEOUT);
        if (!instr_ready) begin
            $display("timeout: instruction was never accepted at %0t", $time);
            errors++;
            timed_out = 1'b1;
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // sampled before the edge updates anything
    always @(posedge clk) begin
        logic [48:0] want;
        if (!reset) begin
            if (win_active && instr_ready && (win_rx + 2 < win_total)) begin
                $display("error: instr_ready went high at %0t while the loop was running",
                         $time);
                errors++;
                win_active = 1'b0;
            end
            if (addr_valid && addr_ready) begin
                if (exp_q.size() == 0) begin
                    $display("error: unexpected address triple at %0t", $time);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    check_value("addr_src1", addr_src1, want[15:0]);
                    check_value("addr_src2", addr_src2, want[31:16]);
                    check_value("addr_dest", addr_dest, want[47:32]);
                    check_value("addr_last", addr_last, want[48]);
                end
                win_rx++;
            end
            if (instr_valid && instr_ready) begin
                win_active = (instr_opcode == OP_LOOP) && (instr_fn == FN_START);
                win_total  = pending_total;
                win_rx     = 0;
            end
        end
    end

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: FAILED with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d address triples never arrived in test %s",
                     exp_q.size(), name);
            errors++;
            timed_out = 1'b1;
        end
        // quiet cycles so stray triples land in this test
        repeat (8) @(negedge clk);
        report_test(name, start_errors);
    endtask

    initial begin
        int                fd;
        int                code;
        int                test_start;
        logic              in_test;
        string             kind;
        string             name;
        logic [8*200-1:0]  skip;
        clk             = 1'b0;
        reset           = 1'b1;
        instr_valid     = 1'b0;
        instr_opcode    = '0;
        instr_fn        = '0;
        instr_loop_id   = '0;
        instr_immediate = '0;
        src1_ns         = '0;
        src1_index      = '0;
        src2_ns         = '0;
        src2_index      = '0;
        dest_ns         = '0;
        dest_index      = '0;
        tbl_wr_valid    = 1'b0;
        tbl_wr_stride   = 1'b0;
        tbl_wr_ns       = '0;
        tbl_wr_index    = '0;
        tbl_wr_data     = '0;
        addr_ready      = 1'b0;
        lfsr_state      = 32'h1fa3_4c8f;
        tests           = 0;
        failed          = 0;
        checks          = 0;
        errors          = 0;
        timed_out       = 1'b0;
        win_active      = 1'b0;
        win_total       = 0;
        win_rx          = 0;
        pending_total   = 0;
        for (int t = 0; t < 2; t++) begin
            for (int n = 0; n < 8; n++) begin
                for (int i = 0; i < 32; i++) begin
                    tbl_copy[t][n][i] = '0;
                end
            end
            for (int p = 0; p < 3; p++) begin
                last_rd[t][p] = '0;
            end
        end
        for (int l = 0; l < NUM_LOOPS; l++) begin
            cfg_count[l] = '0;
            for (int p = 0; p < 3; p++) begin
                cfg_stride[p][l] = '0;
            end
        end
        for (int p = 0; p < 3; p++) begin
            cfg_base[p] = '0;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_start = errors;
        check_value("addr_valid", addr_valid, 16'd0);
        check_value("instr_ready", instr_ready, 16'd1);
        report_test("reset_state", test_start);

        ////////////////////////////////////////
        // pattern replay
        ////////////////////////////////////////
        in_test = 1'b0;
        fd = $fopen("tests/iterator_patterns.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the pattern file");
            errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(skip, fd);
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%h %h %h %h", f_stride, f_ns, f_idx, f_data);
                    if (code == 4) begin
                        drive_write();
                    end else begin
                        $display("error: malformed W record in the pattern file");
                        errors++;
                    end
                end else if (kind == "I") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f_op, f_fn, f_lid,
                                   f_imm, rec_ns[0], rec_idx[0], rec_ns[1], rec_idx[1],
                                   rec_ns[2], rec_idx[2]);
                    if (code == 10) begin
                        drive_instr();
                    end else begin
                        $display("error: malformed I record in the pattern file");
                        errors++;
                    end
                end else if (kind == "C") begin
                    if (in_test) begin
                        finish_test(name, test_start);
                    end
                    code = $fscanf(fd, "%s", name);
                    test_start = errors;
                    in_test = 1'b1;
                end else begin
                    $display("error: unknown record %s in the pattern file", kind);
                    errors++;
                end
            end
            $fclose(fd);
            if (in_test) begin
                finish_test(name, test_start);
            end
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks,
                 errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/iterator_patterns.txt */
# W table(0 base 1 stride) ns index data
# I opcode fn loop_id immediate src1_ns src1_idx src2_ns src2_idx dest_ns dest_idx then C name
C single_loop
W 0 0 00 0000
W 1 0 00 0000
W 0 1 02 1000
W 0 2 02 2000
W 0 3 02 3000
W 1 1 02 0004
W 1 2 02 0008
W 1 3 02 0010
I 7 1 3 0005 0 00 0 00 0 00
I 7 0 3 0000 1 02 2 02 3 02
I 7 3 0 0000 1 02 2 02 3 02
I 7 2 0 0000 0 00 0 00 0 00
C nest3_backpressure
W 1 1 05 0100
W 1 2 05 0200
W 1 3 05 7000
W 1 1 06 0010
W 1 2 06 0020
W 1 3 06 0030
W 1 1 07 0001
W 1 2 07 0002
W 1 3 07 0003
I 7 1 1 0003 0 00 0 00 0 00
I 7 1 2 0004 0 00 0 00 0 00
I 7 1 3 0002 0 00 0 00 0 00
I 7 0 1 0000 1 05 2 05 3 05
I 7 0 2 0000 1 06 2 06 3 06
I 7 0 3 0000 1 07 2 07 3 07
I 7 3 0 0000 1 02 2 02 3 02
I 7 2 0 0000 0 00 0 00 0 00
C busy_hold
I 7 1 3 0008 0 00 0 00 0 00
I 7 0 3 0000 1 02 2 02 3 02
I 7 3 0 0000 1 02 2 02 3 02
I 7 2 0 0000 0 00 0 00 0 00
I 5 2 0 0000 0 00 0 00 0 00
C cleared_config
W 0 0 09 0123
W 0 1 09 0456
W 0 3 09 0789
W 0 7 09 dead
W 1 7 09 beef
I 7 3 0 0000 0 09 1 09 3 09
I 7 2 0 0000 0 00 0 00 0 00

/* files.f */
hw/iter_pkg.sv
hw/iter_decode.sv
hw/base_stride_table.sv
hw/loop_config.sv
hw/nested_loop_gen.sv
hw/addr_result.sv
hw/iterator_top.sv
tests/iterator_tb.sv
